// ==== logic/locator_pkg.sv ====
`default_nettype none

package locator_pkg;

    // one color or chroma sample
    localparam int COLOR_WIDTH = 8;

    // raster coordinate widths
    // horizontal covers up to 2048 columns
    localparam int H_WIDTH = 11;
    // vertical covers up to 1024 lines
    localparam int V_WIDTH = 10;

    // single 8-bit channel sample
    typedef logic [COLOR_WIDTH-1:0] color_t;

    // column index within the raster
    typedef logic [H_WIDTH-1:0] hcoord_t;

    // line index within the raster
    typedef logic [V_WIDTH-1:0] vcoord_t;

    // overlay display opcode
    // camera passes the pixel through untouched
    // mask shows detect0 on red and detect1 on blue
    // magenta paints detect1 pixels over the camera image
    // 2'b11 is unused and falls back to camera
    typedef enum logic [1:0] {
        MODE_CAMERA  = 2'b00,
        MODE_MASK    = 2'b01,
        MODE_MAGENTA = 2'b10
    } display_mode_e;

endpackage

`default_nettype wire

// ==== logic/pixel_raster_if.sv ====
`default_nettype none

// raster position bundle shared between pipeline stages
interface pixel_raster_if;

    // current column and line
    locator_pkg::hcoord_t hcount;
    locator_pkg::vcoord_t vcount;

    // high inside the visible area
    logic active;

    // single-cycle pulse at the first blanking pixel after the last line
    logic new_frame;

    // the stage that produces this position
    modport source(output hcount, output vcount, output active, output new_frame);

    // the stages that consume it
    modport sink(input hcount, input vcount, input active, input new_frame);

endinterface

`default_nettype wire

// ==== logic/raster_timing.sv ====
`default_nettype none

module raster_timing #(
    parameter int H_ACTIVE = 1280,
    parameter int V_ACTIVE = 720,
    parameter int H_TOTAL  = 1650,
    parameter int V_TOTAL  = 750
) (
    input wire             clk_pixel,
    input wire             sys_rst_pixel,
    pixel_raster_if.source raster
);

    // last column and last line of the whole raster, blanking included
    localparam locator_pkg::hcoord_t H_LAST = locator_pkg::hcoord_t'(H_TOTAL - 1);
    localparam locator_pkg::vcoord_t V_LAST = locator_pkg::vcoord_t'(V_TOTAL - 1);

    // first position past the visible area on each axis
    localparam locator_pkg::hcoord_t H_END = locator_pkg::hcoord_t'(H_ACTIVE);
    localparam locator_pkg::vcoord_t V_END = locator_pkg::vcoord_t'(V_ACTIVE);

    locator_pkg::hcoord_t h_count;
    locator_pkg::vcoord_t v_count;
    locator_pkg::hcoord_t h_next;
    locator_pkg::vcoord_t v_next;
    logic                 nf_next;
    logic                 new_frame_q;

    // next scan position
    // line advances only when the column wraps
    always_comb begin
        h_next = h_count + 1'b1;
        v_next = v_count;
        if (h_count == H_LAST) begin
            h_next = '0;
            v_next = (v_count == V_LAST) ? '0 : v_count + 1'b1;
        end
        // flag the first blanking pixel after the last visible line
        nf_next = (h_next == H_END) && (v_next == V_END);
    end

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            h_count     <= '0;
            v_count     <= '0;
            new_frame_q <= 1'b0;
        end else begin
            h_count     <= h_next;
            v_count     <= v_next;
            // registered so the pulse lines up with the counters
            new_frame_q <= nf_next;
        end
    end

    assign raster.hcount    = h_count;
    assign raster.vcount    = v_count;
    // visible area decoded straight from the counters
    assign raster.active    = (h_count < H_END) && (v_count < V_END);
    assign raster.new_frame = new_frame_q;

endmodule

`default_nettype wire

// ==== logic/chroma_threshold.sv ====
`default_nettype none

module chroma_threshold (
    input wire                   clk_pixel,
    input wire                   sys_rst_pixel,
    pixel_raster_if.sink         raster_in,
    input wire locator_pkg::color_t cr,
    input wire locator_pkg::color_t cb,
    input wire locator_pkg::color_t lower_bound,
    input wire locator_pkg::color_t upper_bound,
    pixel_raster_if.source       raster_out,
    output logic                 detect0,
    output logic                 detect1
);

    // inclusive window test shared by both chroma channels
    function automatic logic in_window(input locator_pkg::color_t sample,
                                       input locator_pkg::color_t lo,
                                       input locator_pkg::color_t hi);
        return (sample >= lo) && (sample <= hi);
    endfunction

    locator_pkg::hcoord_t hcount_d1;
    locator_pkg::vcoord_t vcount_d1;
    logic                 active_d1;
    logic                 new_frame_d1;

    // coordinates ride along with the detect bits
    // so both consumers see them on the same cycle
    always_ff @(posedge clk_pixel) begin
        hcount_d1 <= raster_in.hcount;
        vcount_d1 <= raster_in.vcount;
    end

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            active_d1    <= 1'b0;
            new_frame_d1 <= 1'b0;
            detect0      <= 1'b0;
            detect1      <= 1'b0;
        end else begin
            active_d1    <= raster_in.active;
            new_frame_d1 <= raster_in.new_frame;
            // cr window marks detect0
            detect0      <= raster_in.active && in_window(cr, lower_bound, upper_bound);
            // cb window marks detect1, the bit the tracker follows
            detect1      <= raster_in.active && in_window(cb, lower_bound, upper_bound);
        end
    end

    // one-cycle delayed raster for the tracker and the overlay
    assign raster_out.hcount    = hcount_d1;
    assign raster_out.vcount    = vcount_d1;
    assign raster_out.active    = active_d1;
    assign raster_out.new_frame = new_frame_d1;

endmodule

`default_nettype wire

// ==== logic/centroid_tracker.sv ====
`default_nettype none

module centroid_tracker #(
    parameter int H_ACTIVE = 1280,
    parameter int V_ACTIVE = 720
) (
    input wire                   clk_pixel,
    input wire                   sys_rst_pixel,
    pixel_raster_if.sink         raster,
    input wire                   detect1,
    output locator_pkg::hcoord_t x_com,
    output locator_pkg::vcoord_t y_com,
    output logic                 com_valid
);

    // worst case is every visible pixel lit
    localparam longint AREA   = longint'(H_ACTIVE) * longint'(V_ACTIVE);
    localparam int     CNT_W  = $clog2(AREA + 1);
    localparam int     XSUM_W = $clog2(AREA * H_ACTIVE + 1);
    localparam int     YSUM_W = $clog2(AREA * V_ACTIVE + 1);
    localparam int     SUM_W  = (XSUM_W > YSUM_W) ? XSUM_W : YSUM_W;
    // room for the count shifted up by the widest quotient
    localparam int     DIV_W  = SUM_W + locator_pkg::H_WIDTH;
    localparam int     BIT_W  = $clog2(locator_pkg::H_WIDTH);

    localparam logic [BIT_W-1:0] H_MSB = BIT_W'(locator_pkg::H_WIDTH - 1);
    localparam logic [BIT_W-1:0] V_MSB = BIT_W'(locator_pkg::V_WIDTH - 1);

    typedef enum logic [1:0] {
        IDLE,
        DIV_X,
        DIV_Y
    } div_state_e;

    div_state_e           state;
    logic [XSUM_W-1:0]    x_acc;
    logic [YSUM_W-1:0]    y_acc;
    logic [CNT_W-1:0]     cnt_acc;
    logic [YSUM_W-1:0]    y_snap;
    logic [CNT_W-1:0]     cnt_snap;
    logic [SUM_W-1:0]     rem;
    logic [SUM_W-1:0]     rem_left;
    logic [DIV_W-1:0]     rem_wide;
    logic [DIV_W-1:0]     den_shift;
    logic [BIT_W-1:0]     bit_idx;
    logic                 fits;
    logic                 start_div;
    locator_pkg::hcoord_t x_quo;
    locator_pkg::vcoord_t y_quo;

    // empty frames never reach the divider
    assign start_div = raster.new_frame && (cnt_acc != '0);

    // per-frame sums of lit coordinates
    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            x_acc   <= '0;
            y_acc   <= '0;
            cnt_acc <= '0;
        end else if (raster.new_frame) begin
            // snapshot happens on this same edge
            x_acc   <= '0;
            y_acc   <= '0;
            cnt_acc <= '0;
        end else if (raster.active && detect1) begin
            x_acc   <= x_acc + XSUM_W'(raster.hcount);
            y_acc   <= y_acc + YSUM_W'(raster.vcount);
            cnt_acc <= cnt_acc + 1'b1;
        end
    end

    // restoring step, divisor shifted to the current quotient bit
    always_comb begin
        den_shift = DIV_W'(cnt_snap) << bit_idx;
        rem_wide  = DIV_W'(rem);
        fits      = rem_wide >= den_shift;
        rem_left  = fits ? SUM_W'(rem_wide - den_shift) : rem;
    end

    // divider datapath
    always_ff @(posedge clk_pixel) begin
        if (start_div) begin
            rem      <= SUM_W'(x_acc);
            y_snap   <= y_acc;
            cnt_snap <= cnt_acc;
        end else if (state == DIV_X) begin
            x_quo <= {x_quo[locator_pkg::H_WIDTH-2:0], fits};
            // y sum takes over once the last x bit is out
            rem   <= (bit_idx == '0) ? SUM_W'(y_snap) : rem_left;
        end else if (state == DIV_Y) begin
            y_quo <= {y_quo[locator_pkg::V_WIDTH-2:0], fits};
            rem   <= rem_left;
        end
    end

    // divider control, one quotient bit per cycle msb first
    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            state     <= IDLE;
            bit_idx   <= '0;
            x_com     <= '0;
            y_com     <= '0;
            com_valid <= 1'b0;
        end else begin
            com_valid <= 1'b0;
            if (start_div) begin
                state   <= DIV_X;
                bit_idx <= H_MSB;
            end else begin
                case (state)
                    DIV_X: begin
                        bit_idx <= bit_idx - 1'b1;
                        if (bit_idx == '0) begin
                            state   <= DIV_Y;
                            bit_idx <= V_MSB;
                        end
                    end
                    DIV_Y: begin
                        bit_idx <= bit_idx - 1'b1;
                        if (bit_idx == '0) begin
                            state     <= IDLE;
                            x_com     <= x_quo;
                            y_com     <= {y_quo[locator_pkg::V_WIDTH-2:0], fits};
                            com_valid <= 1'b1;
                        end
                    end
                    default: begin
                        state <= IDLE;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/overlay_mux.sv ====
`default_nettype none

module overlay_mux (
    input wire                          clk_pixel,
    input wire                          sys_rst_pixel,
    pixel_raster_if.sink                raster,
    input wire                          detect0,
    input wire                          detect1,
    input wire locator_pkg::color_t     cam_red,
    input wire locator_pkg::color_t     cam_green,
    input wire locator_pkg::color_t     cam_blue,
    input wire locator_pkg::display_mode_e mode,
    input wire                          crosshair_on,
    input wire locator_pkg::hcoord_t    x_com,
    input wire locator_pkg::vcoord_t    y_com,
    output locator_pkg::color_t         out_red,
    output locator_pkg::color_t         out_green,
    output locator_pkg::color_t         out_blue,
    output logic                        out_active
);

    locator_pkg::color_t cam_red_d1;
    locator_pkg::color_t cam_green_d1;
    locator_pkg::color_t cam_blue_d1;
    locator_pkg::color_t mix_red;
    locator_pkg::color_t mix_green;
    locator_pkg::color_t mix_blue;
    logic                on_cross;

    // camera pixel catches up with the thresholder delay
    always_ff @(posedge clk_pixel) begin
        cam_red_d1   <= cam_red;
        cam_green_d1 <= cam_green;
        cam_blue_d1  <= cam_blue;
    end

    always_comb begin
        mix_red   = cam_red_d1;
        mix_green = cam_green_d1;
        mix_blue  = cam_blue_d1;
        case (mode)
            locator_pkg::MODE_MASK: begin
                mix_red   = detect0 ? '1 : '0;
                mix_green = '0;
                mix_blue  = detect1 ? '1 : '0;
            end
            locator_pkg::MODE_MAGENTA: begin
                // only cb hits get painted
                if (detect1) begin
                    mix_red   = '1;
                    mix_green = '0;
                    mix_blue  = '1;
                end
            end
            default: begin
                // camera and the spare code keep the delayed camera pixel
            end
        endcase
        // crosshair sits on top of every mode
        on_cross = crosshair_on && ((raster.hcount == x_com) || (raster.vcount == y_com));
        if (on_cross) begin
            mix_red   = '1;
            mix_green = '1;
            mix_blue  = '1;
        end
        // blanking stays black
        if (!raster.active) begin
            mix_red   = '0;
            mix_green = '0;
            mix_blue  = '0;
        end
    end

    always_ff @(posedge clk_pixel) begin
        if (sys_rst_pixel) begin
            out_red    <= '0;
            out_green  <= '0;
            out_blue   <= '0;
            out_active <= 1'b0;
        end else begin
            out_red    <= mix_red;
            out_green  <= mix_green;
            out_blue   <= mix_blue;
            out_active <= raster.active;
        end
    end

endmodule

`default_nettype wire

// ==== logic/led_locator_top.sv ====
`default_nettype none

module led_locator_top #(
    parameter int H_ACTIVE = 1280,
    parameter int V_ACTIVE = 720,
    parameter int H_TOTAL  = 1650,
    parameter int V_TOTAL  = 750
) (
    input wire                             clk_pixel,
    input wire                             sys_rst_pixel,
    // camera sample for the current hcount and vcount
    input wire locator_pkg::color_t        cam_red,
    input wire locator_pkg::color_t        cam_green,
    input wire locator_pkg::color_t        cam_blue,
    input wire locator_pkg::color_t        cam_cr,
    input wire locator_pkg::color_t        cam_cb,
    // threshold window, shared by cr and cb
    input wire locator_pkg::color_t        lower_bound,
    input wire locator_pkg::color_t        upper_bound,
    input wire locator_pkg::display_mode_e mode,
    input wire                             crosshair_on,
    // current raster position
    output locator_pkg::hcoord_t           hcount,
    output locator_pkg::vcoord_t           vcount,
    output logic                           active,
    // composed pixel, two cycles behind the raster
    output locator_pkg::color_t            out_red,
    output locator_pkg::color_t            out_green,
    output locator_pkg::color_t            out_blue,
    output logic                           out_active,
    // centroid of the cb detections
    output locator_pkg::hcoord_t           x_com,
    output locator_pkg::vcoord_t           y_com,
    output logic                           com_valid
);

    logic detect0;
    logic detect1;

    // raster as generated, and one cycle later
    pixel_raster_if raster_now ();
    pixel_raster_if raster_d1 ();

    raster_timing #(
        .H_ACTIVE(H_ACTIVE),
        .V_ACTIVE(V_ACTIVE),
        .H_TOTAL (H_TOTAL),
        .V_TOTAL (V_TOTAL)
    ) u_raster_timing (
        .clk_pixel    (clk_pixel),
        .sys_rst_pixel(sys_rst_pixel),
        .raster       (raster_now)
    );

    chroma_threshold u_chroma_threshold (
        .clk_pixel    (clk_pixel),
        .sys_rst_pixel(sys_rst_pixel),
        .raster_in    (raster_now),
        .cr           (cam_cr),
        .cb           (cam_cb),
        .lower_bound  (lower_bound),
        .upper_bound  (upper_bound),
        .raster_out   (raster_d1),
        .detect0      (detect0),
        .detect1      (detect1)
    );

    centroid_tracker #(
        .H_ACTIVE(H_ACTIVE),
        .V_ACTIVE(V_ACTIVE)
    ) u_centroid_tracker (
        .clk_pixel    (clk_pixel),
        .sys_rst_pixel(sys_rst_pixel),
        .raster       (raster_d1),
        .detect1      (detect1),
        .x_com        (x_com),
        .y_com        (y_com),
        .com_valid    (com_valid)
    );

    overlay_mux u_overlay_mux (
        .clk_pixel    (clk_pixel),
        .sys_rst_pixel(sys_rst_pixel),
        .raster       (raster_d1),
        .detect0      (detect0),
        .detect1      (detect1),
        .cam_red      (cam_red),
        .cam_green    (cam_green),
        .cam_blue     (cam_blue),
        .mode         (mode),
        .crosshair_on (crosshair_on),
        .x_com        (x_com),
        .y_com        (y_com),
        .out_red      (out_red),
        .out_green    (out_green),
        .out_blue     (out_blue),
        .out_active   (out_active)
    );

    // the pixel source looks up its sample from these
    assign hcount = raster_now.hcount;
    assign vcount = raster_now.vcount;
    assign active = raster_now.active;

endmodule

`default_nettype wire

// ==== tests/locator_assertions.sv ====
`default_nettype none

module locator_assertions #(
    parameter int H_ACTIVE = 1280,
    parameter int V_ACTIVE = 720
) (
    input wire                      clk_pixel,
    input wire                      sys_rst_pixel,
    input wire                      new_frame,
    input wire                      com_valid,
    input wire locator_pkg::hcoord_t x_com,
    input wire locator_pkg::vcoord_t y_com,
    input wire                      out_active,
    input wire locator_pkg::color_t out_red,
    input wire locator_pkg::color_t out_green,
    input wire locator_pkg::color_t out_blue
);

    // frame marker lasts one pixel
    nf_single: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
        new_frame |=> !new_frame)
        else $error("new_frame high for two cycles");

    // centroid update is a pulse
    cv_single: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
        com_valid |=> !com_valid)
        else $error("com_valid high for two cycles");

    // nothing shows in blanking
    blank_black: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
        !out_active |-> (out_red == '0) && (out_green == '0) && (out_blue == '0))
        else $error("nonzero pixel while out_active is low");

    // centroid lands inside the visible area
    com_inside: assert property (@(posedge clk_pixel) disable iff (sys_rst_pixel)
        com_valid |-> (int'(x_com) < H_ACTIVE) && (int'(y_com) < V_ACTIVE))
        else $error("centroid outside the active area");

endmodule

bind led_locator_top locator_assertions #(
    .H_ACTIVE(H_ACTIVE),
    .V_ACTIVE(V_ACTIVE)
) u_locator_assertions (
    .clk_pixel    (clk_pixel),
    .sys_rst_pixel(sys_rst_pixel),
    .new_frame    (raster_now.new_frame),
    .com_valid    (com_valid),
    .x_com        (x_com),
    .y_com        (y_com),
    .out_active   (out_active),
    .out_red      (out_red),
    .out_green    (out_green),
    .out_blue     (out_blue)
);

`default_nettype wire

// ==== tests/locator_tb.sv ====
`default_nettype none

module locator_tb;

    // small raster so a frame is only 800 cycles
    localparam int H_ACTIVE = 32;
    localparam int V_ACTIVE = 16;
    localparam int H_TOTAL = 40;
    localparam int V_TOTAL = 20;
    // words per golden line and room for frames
    localparam int FIELDS = 12;
    localparam int MAX_FRAMES = 16;
    localparam logic [15:0] NO_UPDATE = 16'h0fff;

    logic clk_pixel;
    logic sys_rst_pixel;
    locator_pkg::color_t cam_red;
    locator_pkg::color_t cam_green;
    locator_pkg::color_t cam_blue;
    locator_pkg::color_t cam_cr;
    locator_pkg::color_t cam_cb;
    locator_pkg::color_t lower_bound;
    locator_pkg::color_t upper_bound;
    locator_pkg::display_mode_e mode;
    logic crosshair_on;
    locator_pkg::hcoord_t hcount;
    locator_pkg::vcoord_t vcount;
    logic active;
    locator_pkg::color_t out_red;
    locator_pkg::color_t out_green;
    locator_pkg::color_t out_blue;
    logic out_active;
    locator_pkg::hcoord_t x_com;
    locator_pkg::vcoord_t y_com;
    logic com_valid;

    logic [15:0] golden_mem [0:FIELDS*MAX_FRAMES-1];
    // expected {out_active, red, green, blue} in flight, oldest first
    logic [24:0] pix_queue [$];
    int cr_box [4];
    int cb_box [4];
    int frame_count;
    int fail_count;
    int cycle_count;
    int timeout_cycles;
    // centroid the DUT should be holding
    locator_pkg::hcoord_t model_x;
    locator_pkg::vcoord_t model_y;
    // centroid still owed for the current frame
    logic pending;
    locator_pkg::hcoord_t pend_x;
    locator_pkg::vcoord_t pend_y;
    // scan position expected on the next falling edge
    locator_pkg::hcoord_t exp_h;
    locator_pkg::vcoord_t exp_v;

    led_locator_top #(
        .H_ACTIVE(H_ACTIVE),
        .V_ACTIVE(V_ACTIVE),
        .H_TOTAL (H_TOTAL),
        .V_TOTAL (V_TOTAL)
    ) u_led_locator_top (
        .clk_pixel    (clk_pixel),
        .sys_rst_pixel(sys_rst_pixel),
        .cam_red      (cam_red),
        .cam_green    (cam_green),
        .cam_blue     (cam_blue),
        .cam_cr       (cam_cr),
        .cam_cb       (cam_cb),
        .lower_bound  (lower_bound),
        .upper_bound  (upper_bound),
        .mode         (mode),
        .crosshair_on (crosshair_on),
        .hcount       (hcount),
        .vcount       (vcount),
        .active       (active),
        .out_red      (out_red),
        .out_green    (out_green),
        .out_blue     (out_blue),
        .out_active   (out_active),
        .x_com        (x_com),
        .y_com        (y_com),
        .com_valid    (com_valid)
    );

    initial begin
        clk_pixel = 1'b0;
        forever #50 clk_pixel = ~clk_pixel;
    end

    task automatic report_failure(input string what);
        fail_count = fail_count + 1;
        $display("%s", what);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped at first failure");
    endtask

    // cycle budget is set once the golden file is counted
    always @(posedge clk_pixel) begin
        cycle_count = cycle_count + 1;
        if (timeout_cycles != 0 && cycle_count >= timeout_cycles) begin
            report_failure($sformatf("timeout after %0d cycles", cycle_count));
        end
    end

    task automatic check_color(input string name, input locator_pkg::color_t got,
                               input locator_pkg::color_t exp);
        if (got !== exp) begin
            report_failure($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_coord_h(input string name, input locator_pkg::hcoord_t got,
                                 input locator_pkg::hcoord_t exp);
        if (got !== exp) begin
            report_failure($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_coord_v(input string name, input locator_pkg::vcoord_t got,
                                 input locator_pkg::vcoord_t exp);
        if (got !== exp) begin
            report_failure($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("ERR %s got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    // inclusive box, empty when x0 is above x1
    function automatic logic in_rect(input int x0, input int y0, input int x1, input int y1,
                                     input int h, input int v);
        return (h >= x0) && (h <= x1) && (v >= y0) && (v <= y1);
    endfunction

    // composed pixel per the display mode and crosshair rules
    function automatic logic [24:0] expected_pixel(input logic act, input logic det0,
                                                   input logic det1, input int h, input int v,
                                                   input locator_pkg::color_t r,
                                                   input locator_pkg::color_t g,
                                                   input locator_pkg::color_t b);
        locator_pkg::color_t er;
        locator_pkg::color_t eg;
        locator_pkg::color_t eb;
        er = r;
        eg = g;
        eb = b;
        if (mode == locator_pkg::MODE_MASK) begin
            er = det0 ? 8'hff : 8'h00;
            eg = 8'h00;
            eb = det1 ? 8'hff : 8'h00;
        end else if (mode == locator_pkg::MODE_MAGENTA && det1) begin
            er = 8'hff;
            eg = 8'h00;
            eb = 8'hff;
        end
        if (crosshair_on && (h == int'(model_x) || v == int'(model_y))) begin
            er = 8'hff;
            eg = 8'hff;
            eb = 8'hff;
        end
        // blanking is black
        if (!act) begin
            er = 8'h00;
            eg = 8'h00;
            eb = 8'h00;
        end
        return {act, er, eg, eb};
    endfunction

    task automatic load_frame(input int f);
        int base;
        int k;
        base = f * FIELDS;
        for (k = 0; k < 4; k++) begin
            cr_box[k] = int'(golden_mem[base + k]);
            cb_box[k] = int'(golden_mem[base + 4 + k]);
        end
        mode = locator_pkg::display_mode_e'(golden_mem[base + 8][1:0]);
        crosshair_on = golden_mem[base + 9][0];
        pending = (golden_mem[base + 10] != NO_UPDATE);
        pend_x = locator_pkg::hcoord_t'(golden_mem[base + 10]);
        pend_y = locator_pkg::vcoord_t'(golden_mem[base + 11]);
    endtask

    // one falling edge: check old outputs, then drive the current position
    task automatic step_pixel();
        logic [24:0] exp_pix;
        logic act;
        logic lit0;
        logic lit1;
        locator_pkg::color_t r;
        locator_pkg::color_t g;
        locator_pkg::color_t b;
        int h;
        int v;
        h = int'(exp_h);
        v = int'(exp_v);
        act = (h < H_ACTIVE) && (v < V_ACTIVE);
        // pixel driven two edges ago is now at the output
        if (pix_queue.size() == 2) begin
            exp_pix = pix_queue.pop_front();
            check_bit("out_active", out_active, exp_pix[24]);
            check_color("out_red", out_red, exp_pix[23:16]);
            check_color("out_green", out_green, exp_pix[15:8]);
            check_color("out_blue", out_blue, exp_pix[7:0]);
        end
        check_coord_h("hcount", hcount, exp_h);
        check_coord_v("vcount", vcount, exp_v);
        check_bit("active", active, act);
        if (com_valid) begin
            if (!pending) begin
                report_failure("com_valid pulsed with no centroid update due");
            end
            check_coord_h("x_com", x_com, pend_x);
            check_coord_v("y_com", y_com, pend_y);
            model_x = pend_x;
            model_y = pend_y;
            pending = 1'b0;
        end
        lit0 = act && in_rect(cr_box[0], cr_box[1], cr_box[2], cr_box[3], h, v);
        lit1 = act && in_rect(cb_box[0], cb_box[1], cb_box[2], cb_box[3], h, v);
        r = locator_pkg::color_t'($urandom);
        g = locator_pkg::color_t'($urandom);
        b = locator_pkg::color_t'($urandom);
        cam_red = r;
        cam_green = g;
        cam_blue = b;
        // unlit chroma stays under the lower bound
        cam_cr = lit0 ? 8'hf0 : locator_pkg::color_t'($urandom % 128);
        cam_cb = lit1 ? 8'hf0 : locator_pkg::color_t'($urandom % 128);
        pix_queue.push_back(expected_pixel(act, lit0, lit1, h, v, r, g, b));
        if (h == H_TOTAL - 1) begin
            exp_h = '0;
            exp_v = (v == V_TOTAL - 1) ? '0 : exp_v + 1'b1;
        end else begin
            exp_h = exp_h + 1'b1;
        end
    endtask

    initial begin
        int i;
        int f;
        sys_rst_pixel = 1'b1;
        cam_red = '0;
        cam_green = '0;
        cam_blue = '0;
        cam_cr = '0;
        cam_cb = '0;
        lower_bound = 8'h80;
        upper_bound = 8'hff;
        mode = locator_pkg::MODE_CAMERA;
        crosshair_on = 1'b0;
        fail_count = 0;
        cycle_count = 0;
        timeout_cycles = 0;
        model_x = '0;
        model_y = '0;
        pending = 1'b0;
        pend_x = '0;
        pend_y = '0;
        exp_h = '0;
        exp_v = '0;
        for (i = 0; i < 4; i++) begin
            cr_box[i] = 0;
            cb_box[i] = 0;
        end
        void'($urandom(32'h7fec_70ea));
        // unwritten words carry f in the top nibble
        for (i = 0; i < FIELDS * MAX_FRAMES; i++) begin
            golden_mem[i] = 16'hf000 | 16'(i);
        end
        $readmemh("tests/locator_golden.txt", golden_mem);
        frame_count = 0;
        while (frame_count < MAX_FRAMES && golden_mem[frame_count * FIELDS][15:12] != 4'hf) begin
            frame_count = frame_count + 1;
        end
        if (frame_count == 0) begin
            report_failure("golden file holds no frames");
        end
        timeout_cycles = (frame_count + 2) * H_TOTAL * V_TOTAL + 100;
        repeat (5) @(posedge clk_pixel);
        @(negedge clk_pixel);
        // reset state of the outputs
        check_bit("out_active", out_active, 1'b0);
        check_bit("com_valid", com_valid, 1'b0);
        check_coord_h("x_com", x_com, '0);
        check_coord_v("y_com", y_com, '0);
        sys_rst_pixel = 1'b0;
        for (f = 0; f < frame_count; f++) begin
            load_frame(f);
            repeat (H_TOTAL * V_TOTAL) begin
                step_pixel();
                @(negedge clk_pixel);
            end
            // centroid must have landed within the frame's own blanking
            if (pending) begin
                report_failure($sformatf("no com_valid pulse for frame %0d", f));
            end
            check_coord_h("x_com", x_com, model_x);
            check_coord_v("y_com", y_com, model_y);
        end
        if (fail_count == 0) begin
            $display("NO ERRORS");
            $finish;
        end else begin
            report_failure("checks failed during the run");
        end
    end

endmodule

`default_nettype wire

// ==== tests/locator_golden.txt ====
// one frame per line in hex: cr box x0 y0 x1 y1, then cb box x0 y0 x1 y1
// then mode, crosshair_on, expected x_com and y_com
// an empty box has x0 above x1 and 0fff 0fff means no centroid update
// small cb box in camera mode
01 00 00 00  04 02 09 05  0 0  0006 0003
// overlapping boxes shown as a mask
0a 03 14 08  0f 06 19 0c  1 0  0014 0009
// magenta in the lower right corner with the crosshair on
00 00 05 05  1c 0a 1f 0f  2 1  001d 000c
// no cb hits so the old centroid stays
01 00 00 00  01 00 00 00  0 1  0fff 0fff
// spare mode code with a single lit pixel at the origin
08 08 0c 0c  00 00 00 00  3 1  0000 0000
// full cr mask and a large cb box
00 00 1f 0f  01 01 1e 0e  1 1  000f 0007
// cr only in magenta mode
03 03 07 07  01 00 00 00  2 0  0fff 0fff
// every visible pixel lit on cb
01 00 00 00  00 00 1f 0f  0 1  000f 0007

// ==== all.f ====
logic/locator_pkg.sv
logic/pixel_raster_if.sv
logic/raster_timing.sv
logic/chroma_threshold.sv
logic/centroid_tracker.sv
logic/overlay_mux.sv
logic/led_locator_top.sv
tests/locator_assertions.sv
tests/locator_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the led locator testbench with Verilator

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
    echo "cannot enter the project directory"
    exit 1
fi

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert --top-module locator_tb \
    -f all.f --Mdir "$BUILD_DIR" -o locator_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/locator_sim" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"

# the log decides the verdict
if grep -q "ERRORS FOUND" "$LOG_FILE"; then
    echo "simulation failed"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
echo "simulation passed"
exit 0
